// File: include/ddl_defs.svh
`ifndef DDL_DEFS_SVH
`define DDL_DEFS_SVH

// Address and data-path widths
`define DDL_ROW_BITS 13
`define DDL_DQ_WIDTH 32
`define DDL_DM_WIDTH 4

// Power-up wait after clock enable, in cycles
`define DDL_T_CKE 5

// Command to command delays, in clock cycles
`define DDL_T_RCD 3
`define DDL_T_RRD 2
`define DDL_T_RD_RD 4
`define DDL_T_WR_WR 4
`define DDL_T_RD_WR 6
`define DDL_T_WR_RD 8
`define DDL_T_RW_ACT 2
`define DDL_T_AP_ACT 10
`define DDL_T_RP 2
`define DDL_T_RFC 9
`define DDL_T_MRD 4
`define DDL_T_ZQINIT 64

// CAS write and read latencies, counted from acceptance
`define DDL_WR_LAT 4
`define DDL_RD_LAT 5

// BL8 occupies four clock cycles
`define DDL_BURST 4

`endif

// File: hdl/ddl_cmd_pkg.sv
package ddl_cmd_pkg;

  // DDR3 command encoding, bits are {RAS#, CAS#, WE#}
  typedef enum logic [2:0] {
    CMD_MODE = 3'b000,
    CMD_REFR = 3'b001,
    CMD_PREC = 3'b010,
    CMD_ACTV = 3'b011,
    CMD_WRIT = 3'b100,
    CMD_READ = 3'b101,
    CMD_ZQCL = 3'b110,
    CMD_NOOP = 3'b111
  } ddl_opcode_e;

  // Link state, named after the last command issued
  typedef enum logic [2:0] {
    ST_IDLE = 3'd0,
    ST_ACTV = 3'd1,
    ST_READ = 3'd2,
    ST_WRIT = 3'd3,
    ST_PREC = 3'd4,
    ST_REFR = 3'd5,
    ST_MODE = 3'd6,
    ST_ZQCL = 3'd7
  } ddl_state_e;

endpackage

// File: hdl/ddl_dfi_pkg.sv
`include "ddl_defs.svh"

package ddl_dfi_pkg;

  typedef logic [2:0] ddl_bank_t;

  // Row address, also carries the column and A10 on read and write
  typedef logic [`DDL_ROW_BITS-1:0] ddl_addr_t;

  typedef logic [`DDL_DQ_WIDTH-1:0] ddl_data_t;
  typedef logic [`DDL_DM_WIDTH-1:0] ddl_mask_t;

endpackage

// File: hdl/ddl_cmd_decode.sv
`timescale 1ns/1ps
`include "ddl_defs.svh"

module ddl_cmd_decode (
  input  ddl_cmd_pkg::ddl_state_e                 state_i,
  input  ddl_cmd_pkg::ddl_opcode_e                cmd_i,
  input  logic                                    auto_pre_i,
  output logic                                    legal_o,
  output ddl_cmd_pkg::ddl_state_e                 next_state_o,
  output logic [$clog2(`DDL_T_ZQINIT + 1)-1:0]    delay_o
);
  import ddl_cmd_pkg::*;

  localparam int DW = $clog2(`DDL_T_ZQINIT + 1);

  // State that a command leaves the link in, NOOP falls back to idle
  function automatic ddl_state_e cmd_state(ddl_opcode_e cmd);
    case (cmd)
      CMD_ACTV: return ST_ACTV;
      CMD_READ: return ST_READ;
      CMD_WRIT: return ST_WRIT;
      CMD_PREC: return ST_PREC;
      CMD_REFR: return ST_REFR;
      CMD_MODE: return ST_MODE;
      CMD_ZQCL: return ST_ZQCL;
      default:  return ST_IDLE;
    endcase
  endfunction

  always_comb begin
    legal_o      = 1'b1;
    next_state_o = cmd_state(cmd_i);
    delay_o      = DW'(1);
    case (state_i)
      ST_IDLE: begin
        case (cmd_i)
          CMD_ACTV: delay_o = DW'(`DDL_T_RCD);
          CMD_PREC: delay_o = DW'(`DDL_T_RP);
          CMD_REFR: delay_o = DW'(`DDL_T_RFC);
          CMD_MODE: delay_o = DW'(`DDL_T_MRD);
          CMD_ZQCL: delay_o = DW'(`DDL_T_ZQINIT);
          CMD_NOOP: delay_o = DW'(1);
          default:  legal_o = 1'b0;
        endcase
      end
      ST_ACTV: begin
        case (cmd_i)
          CMD_READ: delay_o = DW'(`DDL_T_RD_RD);
          CMD_WRIT: delay_o = DW'(`DDL_T_WR_WR);
          CMD_ACTV: delay_o = DW'(`DDL_T_RRD);
          default:  legal_o = 1'b0;
        endcase
      end
      ST_READ: begin
        case (cmd_i)
          CMD_READ: delay_o = DW'(`DDL_T_RD_RD);
          CMD_WRIT: delay_o = DW'(`DDL_T_RD_WR);
          CMD_ACTV: delay_o = DW'(`DDL_T_RW_ACT);
          default:  legal_o = 1'b0;
        endcase
      end
      ST_WRIT: begin
        case (cmd_i)
          CMD_WRIT: delay_o = DW'(`DDL_T_WR_WR);
          CMD_READ: delay_o = DW'(`DDL_T_WR_RD);
          CMD_ACTV: delay_o = DW'(`DDL_T_RW_ACT);
          default:  legal_o = 1'b0;
        endcase
      end
      ST_PREC: begin
        case (cmd_i)
          CMD_ACTV: delay_o = DW'(`DDL_T_RCD);
          CMD_REFR: delay_o = DW'(`DDL_T_RFC);
          CMD_NOOP: delay_o = DW'(`DDL_T_RP);
          default:  legal_o = 1'b0;
        endcase
      end
      ST_REFR: begin
        case (cmd_i)
          CMD_ACTV: delay_o = DW'(`DDL_T_RCD);
          CMD_REFR: delay_o = DW'(`DDL_T_RFC);
          default:  legal_o = 1'b0;
        endcase
      end
      ST_MODE: begin
        case (cmd_i)
          CMD_MODE: delay_o = DW'(`DDL_T_MRD);
          CMD_REFR: delay_o = DW'(`DDL_T_RFC);
          CMD_PREC: delay_o = DW'(`DDL_T_RP);
          CMD_ZQCL: delay_o = DW'(`DDL_T_ZQINIT);
          default:  legal_o = 1'b0;
        endcase
      end
      default: begin
        case (cmd_i)
          CMD_ACTV: delay_o = DW'(`DDL_T_RCD);
          CMD_REFR: delay_o = DW'(`DDL_T_RFC);
          CMD_PREC: delay_o = DW'(`DDL_T_RP);
          default:  legal_o = 1'b0;
        endcase
      end
    endcase

    // Auto-precharge closes the row, so the next command must be an activate
    if (legal_o && auto_pre_i && (cmd_i == CMD_READ || cmd_i == CMD_WRIT)) begin
      next_state_o = ST_IDLE;
      delay_o      = DW'(`DDL_T_AP_ACT);
    end
  end

endmodule

// File: hdl/ddl_cmd_execute.sv
`timescale 1ns/1ps
`include "ddl_defs.svh"

module ddl_cmd_execute (
  input  logic                                    clock,
  input  logic                                    reset,
  input  logic                                    cke_i,
  input  logic                                    req_i,
  input  ddl_cmd_pkg::ddl_opcode_e                cmd_i,
  input  ddl_dfi_pkg::ddl_bank_t                  ba_i,
  input  ddl_dfi_pkg::ddl_addr_t                  adr_i,
  input  logic                                    legal_i,
  input  ddl_cmd_pkg::ddl_state_e                 next_state_i,
  input  logic [$clog2(`DDL_T_ZQINIT + 1)-1:0]    delay_i,
  output ddl_cmd_pkg::ddl_state_e                 state_o,
  output logic                                    run_o,
  output logic                                    rdy_o,
  output logic                                    ras_no,
  output logic                                    cas_no,
  output logic                                    we_no,
  output ddl_dfi_pkg::ddl_bank_t                  bank_o,
  output ddl_dfi_pkg::ddl_addr_t                  addr_o,
  output logic                                    wr_start_o,
  output logic                                    rd_start_o
);
  import ddl_cmd_pkg::*;
  import ddl_dfi_pkg::*;

  localparam int CNT_W = $clog2(`DDL_T_ZQINIT + 1);

  ddl_state_e        state_q;
  logic [CNT_W-1:0]  count_q;
  logic              rdy_q;
  logic              run_q;
  ddl_opcode_e       cmd_q;
  ddl_bank_t         ba_q;
  ddl_addr_t         adr_q;
  logic              wr_start_q;
  logic              rd_start_q;
  logic              restart;
  logic              accept;

  // Dropping clock enable restarts the whole power-up sequence
  assign restart = reset | ~cke_i;
  assign accept  = req_i & rdy_q & legal_i & ~restart;

  // One counter covers the power-up wait and every command delay
  always_ff @(posedge clock) begin
    if (restart) begin
      state_q    <= ST_IDLE;
      count_q    <= CNT_W'(`DDL_T_CKE);
      rdy_q      <= 1'b0;
      run_q      <= 1'b0;
      cmd_q      <= CMD_NOOP;
      wr_start_q <= 1'b0;
      rd_start_q <= 1'b0;
    end else begin
      cmd_q      <= CMD_NOOP;
      wr_start_q <= 1'b0;
      rd_start_q <= 1'b0;
      if (!rdy_q) begin
        count_q <= count_q - 1'b1;
        if (count_q == CNT_W'(1)) begin
          rdy_q <= 1'b1;
          run_q <= 1'b1;
        end
      end else if (accept) begin
        state_q    <= next_state_i;
        count_q    <= delay_i;
        rdy_q      <= 1'b0;
        cmd_q      <= cmd_i;
        wr_start_q <= (cmd_i == CMD_WRIT);
        rd_start_q <= (cmd_i == CMD_READ);
      end
    end
  end

  // Bank and address hold until the next accepted command
  always_ff @(posedge clock) begin
    if (accept) begin
      ba_q  <= ba_i;
      adr_q <= adr_i;
    end
  end

  assign state_o    = state_q;
  assign run_o      = run_q;
  assign rdy_o      = rdy_q;
  assign ras_no     = cmd_q[2];
  assign cas_no     = cmd_q[1];
  assign we_no      = cmd_q[0];
  assign bank_o     = ba_q;
  assign addr_o     = adr_q;
  assign wr_start_o = wr_start_q;
  assign rd_start_o = rd_start_q;

endmodule

// File: hdl/ddl_burst_timer.sv
`timescale 1ns/1ps
`include "ddl_defs.svh"

module ddl_burst_timer #(
  parameter int LATENCY = 4
) (
  input  logic clock,
  input  logic reset,
  input  logic start_i,
  output logic burst_o
);

  // The issue register and the burst shifter make up the other two stages
  localparam int DEPTH = LATENCY - 2;

  logic [DEPTH-1:0]      line_q;
  logic [`DDL_BURST-1:0] burst_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      line_q  <= '0;
      burst_q <= '0;
    end else begin
      line_q <= (line_q << 1) | DEPTH'(start_i);
      // A new pulse reloads the shifter, so back-to-back bursts merge
      if (line_q[DEPTH-1]) begin
        burst_q <= '1;
      end else begin
        burst_q <= burst_q >> 1;
      end
    end
  end

  assign burst_o = |burst_q;

endmodule

// File: hdl/ddr3_ddl.sv
`timescale 1ns/1ps
`include "ddl_defs.svh"

module ddr3_ddl (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      ddr_cke_i,

  // Memory controller command port
  output logic                      ctl_run_o,
  input  logic                      ctl_req_i,
  output logic                      ctl_rdy_o,
  input  ddl_cmd_pkg::ddl_opcode_e  ctl_cmd_i,
  input  ddl_dfi_pkg::ddl_bank_t    ctl_ba_i,
  input  ddl_dfi_pkg::ddl_addr_t    ctl_adr_i,

  // Write and read data paths
  input  ddl_dfi_pkg::ddl_mask_t    mem_wrmask_i,
  input  ddl_dfi_pkg::ddl_data_t    mem_wrdata_i,
  output logic                      mem_wready_o,
  output logic                      mem_rvalid_o,
  output ddl_dfi_pkg::ddl_data_t    mem_rddata_o,

  // DFI-style PHY side
  output logic                      dfi_ras_no,
  output logic                      dfi_cas_no,
  output logic                      dfi_we_no,
  output ddl_dfi_pkg::ddl_bank_t    dfi_bank_o,
  output ddl_dfi_pkg::ddl_addr_t    dfi_addr_o,
  output logic                      dfi_wstb_o,
  output logic                      dfi_wren_o,
  output ddl_dfi_pkg::ddl_mask_t    dfi_mask_o,
  output ddl_dfi_pkg::ddl_data_t    dfi_data_o,
  output logic                      dfi_rden_o,
  input  logic                      dfi_rvld_i,
  input  ddl_dfi_pkg::ddl_data_t    dfi_data_i
);
  import ddl_cmd_pkg::*;

  ddl_state_e                           state_w;
  ddl_state_e                           next_state_w;
  logic                                 legal_w;
  logic [$clog2(`DDL_T_ZQINIT + 1)-1:0] delay_w;
  logic                                 wr_start_w;
  logic                                 rd_start_w;

  ddl_cmd_decode decode0 (
    .state_i      (state_w),
    .cmd_i        (ctl_cmd_i),
    .auto_pre_i   (ctl_adr_i[10]),
    .legal_o      (legal_w),
    .next_state_o (next_state_w),
    .delay_o      (delay_w)
  );

  ddl_cmd_execute execute0 (
    .clock        (clock),
    .reset        (reset),
    .cke_i        (ddr_cke_i),
    .req_i        (ctl_req_i),
    .cmd_i        (ctl_cmd_i),
    .ba_i         (ctl_ba_i),
    .adr_i        (ctl_adr_i),
    .legal_i      (legal_w),
    .next_state_i (next_state_w),
    .delay_i      (delay_w),
    .state_o      (state_w),
    .run_o        (ctl_run_o),
    .rdy_o        (ctl_rdy_o),
    .ras_no       (dfi_ras_no),
    .cas_no       (dfi_cas_no),
    .we_no        (dfi_we_no),
    .bank_o       (dfi_bank_o),
    .addr_o       (dfi_addr_o),
    .wr_start_o   (wr_start_w),
    .rd_start_o   (rd_start_w)
  );

  ddl_burst_timer #(.LATENCY(`DDL_WR_LAT)) wr_timer (
    .clock   (clock),
    .reset   (reset | ~ddr_cke_i),
    .start_i (wr_start_w),
    .burst_o (dfi_wstb_o)
  );

  // Write enable trails the strobe by one cycle
  ddl_burst_timer #(.LATENCY(`DDL_WR_LAT + 1)) wren_timer (
    .clock   (clock),
    .reset   (reset | ~ddr_cke_i),
    .start_i (wr_start_w),
    .burst_o (dfi_wren_o)
  );

  ddl_burst_timer #(.LATENCY(`DDL_RD_LAT)) rd_timer (
    .clock   (clock),
    .reset   (reset | ~ddr_cke_i),
    .start_i (rd_start_w),
    .burst_o (dfi_rden_o)
  );

  assign mem_wready_o = dfi_wren_o;
  assign dfi_mask_o   = mem_wrmask_i;
  assign dfi_data_o   = mem_wrdata_i;
  assign mem_rvalid_o = dfi_rvld_i;
  assign mem_rddata_o = dfi_data_i;

endmodule

// File: tb/ddl_properties.sv
`timescale 1ns/1ps

module ddl_properties (
  input logic clock,
  input logic reset,
  input logic ddr_cke_i,
  input logic ctl_run_o,
  input logic dfi_ras_no,
  input logic dfi_cas_no,
  input logic dfi_we_no,
  input logic dfi_wstb_o,
  input logic dfi_wren_o
);

  logic [2:0] cmd;
  logic       restart;
  int         assert_errors = 0;

  assign cmd     = {dfi_ras_no, dfi_cas_no, dfi_we_no};
  assign restart = reset | ~ddr_cke_i;

  // A command is on the bus for one cycle only
  cmd_single: assert property (@(posedge clock) disable iff (reset)
    (cmd != 3'b111) |=> (cmd == 3'b111))
    else begin
      assert_errors++;
      $error("DFI command held for more than one cycle");
    end

  wren_lag: assert property (@(posedge clock) disable iff (restart)
    !$past(restart) |-> (dfi_wren_o == $past(dfi_wstb_o)))
    else begin
      assert_errors++;
      $error("dfi_wren_o does not trail dfi_wstb_o by one cycle");
    end

  run_hold: assert property (@(posedge clock) disable iff (reset)
    $fell(ctl_run_o) |-> $past(restart))
    else begin
      assert_errors++;
      $error("ctl_run_o fell without a restart");
    end

endmodule

bind ddr3_ddl ddl_properties props0 (
  .clock      (clock),
  .reset      (reset),
  .ddr_cke_i  (ddr_cke_i),
  .ctl_run_o  (ctl_run_o),
  .dfi_ras_no (dfi_ras_no),
  .dfi_cas_no (dfi_cas_no),
  .dfi_we_no  (dfi_we_no),
  .dfi_wstb_o (dfi_wstb_o),
  .dfi_wren_o (dfi_wren_o)
);

// File: tb/ddl_checker.sv
`timescale 1ns/1ps
`include "ddl_defs.svh"

module ddl_checker (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     ddr_cke_i,
  input  logic                     ctl_req_i,
  input  logic                     ctl_rdy_o,
  input  logic                     ctl_run_o,
  input  ddl_cmd_pkg::ddl_opcode_e ctl_cmd_i,
  input  ddl_dfi_pkg::ddl_bank_t   ctl_ba_i,
  input  ddl_dfi_pkg::ddl_addr_t   ctl_adr_i,
  input  logic                     dfi_ras_no,
  input  logic                     dfi_cas_no,
  input  logic                     dfi_we_no,
  input  ddl_dfi_pkg::ddl_bank_t   dfi_bank_o,
  input  ddl_dfi_pkg::ddl_addr_t   dfi_addr_o,
  input  logic                     dfi_wstb_o,
  input  logic                     dfi_wren_o,
  input  logic                     mem_wready_o,
  input  logic                     dfi_rden_o,
  input  ddl_dfi_pkg::ddl_mask_t   mem_wrmask_i,
  input  ddl_dfi_pkg::ddl_mask_t   dfi_mask_o,
  input  ddl_dfi_pkg::ddl_data_t   mem_wrdata_i,
  input  ddl_dfi_pkg::ddl_data_t   dfi_data_o,
  input  logic                     dfi_rvld_i,
  input  logic                     mem_rvalid_o,
  input  ddl_dfi_pkg::ddl_data_t   dfi_data_i,
  input  ddl_dfi_pkg::ddl_data_t   mem_rddata_o,
  output int                       error_count_o,
  output int                       test_count_o
);
  import ddl_cmd_pkg::*;
  import ddl_dfi_pkg::*;

  localparam logic [15:0] BURST_ONES = 16'((1 << `DDL_BURST) - 1);

  ddl_state_e  st = ST_IDLE;
  ddl_state_e  nxt;
  ddl_state_e  last_st;
  ddl_opcode_e exp_cmd = CMD_NOOP;
  ddl_opcode_e last_cmd;
  ddl_bank_t   exp_bank;
  ddl_addr_t   exp_addr;
  logic [15:0] wstb_due = '0;
  logic [15:0] wren_due = '0;
  logic [15:0] rden_due = '0;
  bit          active = 0;
  bit          addr_known = 0;
  bit          exp_rdy = 0;
  bit          exp_run = 0;
  bit          powerup = 0;
  bit          pending = 0;
  bit          illegal_q = 0;
  bit          ill_report = 0;
  int          cnt = 0;
  int          dly = 0;
  int          test_errs = 0;
  int          errors = 0;
  int          tests = 0;

  assign error_count_o = errors;
  assign test_count_o  = tests;

  // DDR3 transition table giving legality, state after the command and ready delay
  function automatic bit ref_transition(input ddl_state_e s, input ddl_opcode_e c,
                                        input bit ap, output ddl_state_e n, output int d);
    bit ok;
    ok = 1;
    d  = 0;
    case (c)
      CMD_ACTV: n = ST_ACTV;
      CMD_READ: n = ST_READ;
      CMD_WRIT: n = ST_WRIT;
      CMD_PREC: n = ST_PREC;
      CMD_REFR: n = ST_REFR;
      CMD_MODE: n = ST_MODE;
      CMD_ZQCL: n = ST_ZQCL;
      default:  n = ST_IDLE;
    endcase
    if (s == ST_IDLE && c == CMD_ACTV) d = `DDL_T_RCD;
    else if (s == ST_IDLE && c == CMD_PREC) d = `DDL_T_RP;
    else if (s == ST_IDLE && c == CMD_REFR) d = `DDL_T_RFC;
    else if (s == ST_IDLE && c == CMD_MODE) d = `DDL_T_MRD;
    else if (s == ST_IDLE && c == CMD_ZQCL) d = `DDL_T_ZQINIT;
    else if (s == ST_IDLE && c == CMD_NOOP) d = 1;
    else if (s == ST_ACTV && c == CMD_READ) d = `DDL_T_RD_RD;
    else if (s == ST_ACTV && c == CMD_WRIT) d = `DDL_T_WR_WR;
    else if (s == ST_ACTV && c == CMD_ACTV) d = `DDL_T_RRD;
    else if (s == ST_READ && c == CMD_READ) d = `DDL_T_RD_RD;
    else if (s == ST_READ && c == CMD_WRIT) d = `DDL_T_RD_WR;
    else if (s == ST_WRIT && c == CMD_WRIT) d = `DDL_T_WR_WR;
    else if (s == ST_WRIT && c == CMD_READ) d = `DDL_T_WR_RD;
    else if ((s == ST_READ || s == ST_WRIT) && c == CMD_ACTV) d = `DDL_T_RW_ACT;
    else if ((s == ST_PREC || s == ST_REFR || s == ST_ZQCL) && c == CMD_ACTV) d = `DDL_T_RCD;
    else if (s != ST_IDLE && s != ST_ACTV && s != ST_READ && s != ST_WRIT && c == CMD_REFR)
      d = `DDL_T_RFC;
    else if (s == ST_PREC && c == CMD_NOOP) d = `DDL_T_RP;
    else if ((s == ST_MODE || s == ST_ZQCL) && c == CMD_PREC) d = `DDL_T_RP;
    else if (s == ST_MODE && c == CMD_MODE) d = `DDL_T_MRD;
    else if (s == ST_MODE && c == CMD_ZQCL) d = `DDL_T_ZQINIT;
    else ok = 0;
    if (ok && ap && (c == CMD_READ || c == CMD_WRIT)) begin
      n = ST_IDLE;
      d = `DDL_T_AP_ACT;
    end
    return ok;
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got) begin
      $display("Fail at %0t: %s expected %h got %h", $time, name, exp, got);
      errors++;
      test_errs++;
    end
  endtask

  always @(posedge clock) begin
    if (active) begin
      check("ctl_rdy_o", 32'(exp_rdy), 32'(ctl_rdy_o));
      check("ctl_run_o", 32'(exp_run), 32'(ctl_run_o));
      check("dfi command", 32'(exp_cmd), 32'({dfi_ras_no, dfi_cas_no, dfi_we_no}));
      // Bank and address hold from one accepted command to the next
      if (addr_known) begin
        check("dfi_bank_o", 32'(exp_bank), 32'(dfi_bank_o));
        check("dfi_addr_o", 32'(exp_addr), 32'(dfi_addr_o));
      end
      check("dfi_wstb_o", 32'(wstb_due[0]), 32'(dfi_wstb_o));
      check("dfi_wren_o", 32'(wren_due[0]), 32'(dfi_wren_o));
      check("mem_wready_o", 32'(wren_due[0]), 32'(mem_wready_o));
      check("dfi_rden_o", 32'(rden_due[0]), 32'(dfi_rden_o));
      check("dfi_data_o", mem_wrdata_i, dfi_data_o);
      check("dfi_mask_o", 32'(mem_wrmask_i), 32'(dfi_mask_o));
      check("mem_rvalid_o", 32'(dfi_rvld_i), 32'(mem_rvalid_o));
      check("mem_rddata_o", dfi_data_i, mem_rddata_o);
    end
    if (ill_report) begin
      tests++;
      $display("Test %0d: illegal %s in %s dropped, errors %0d",
               tests, last_cmd.name(), last_st.name(), test_errs);
      ill_report = 0;
    end

    // Model update for the next cycle
    wstb_due = wstb_due >> 1;
    wren_due = wren_due >> 1;
    rden_due = rden_due >> 1;
    exp_cmd  = CMD_NOOP;
    if (reset || !ddr_cke_i) begin
      active     = 1;
      addr_known = 0;
      st         = ST_IDLE;
      exp_rdy    = 0;
      exp_run    = 0;
      cnt        = `DDL_T_CKE;
      wstb_due   = '0;
      wren_due   = '0;
      rden_due   = '0;
      powerup    = 1;
      pending    = 0;
      illegal_q  = 0;
      test_errs  = 0;
    end else if (!exp_rdy) begin
      cnt--;
      if (cnt == 0) begin
        exp_rdy = 1;
        exp_run = 1;
        if (powerup || pending) begin
          tests++;
          if (powerup)
            $display("Test %0d: power-up ready after %0d cycles, errors %0d",
                     tests, `DDL_T_CKE, test_errs);
          else
            $display("Test %0d: %s from %s, ready after %0d cycles, errors %0d",
                     tests, last_cmd.name(), last_st.name(), dly, test_errs);
        end
        powerup = 0;
        pending = 0;
      end
    end else if (ctl_req_i) begin
      if (ref_transition(st, ctl_cmd_i, ctl_adr_i[10], nxt, dly)) begin
        last_cmd   = ctl_cmd_i;
        last_st    = st;
        st         = nxt;
        cnt        = dly;
        exp_rdy    = 0;
        exp_cmd    = ctl_cmd_i;
        exp_bank   = ctl_ba_i;
        exp_addr   = ctl_adr_i;
        addr_known = 1;
        pending    = 1;
        test_errs  = 0;
        illegal_q  = 0;
        if (ctl_cmd_i == CMD_WRIT) begin
          wstb_due = wstb_due | (BURST_ONES << (`DDL_WR_LAT - 1));
          wren_due = wren_due | (BURST_ONES << `DDL_WR_LAT);
        end
        if (ctl_cmd_i == CMD_READ)
          rden_due = rden_due | (BURST_ONES << (`DDL_RD_LAT - 1));
      end else begin
        if (!illegal_q) begin
          last_cmd   = ctl_cmd_i;
          last_st    = st;
          test_errs  = 0;
          ill_report = 1;
        end
        illegal_q = 1;
      end
    end else begin
      illegal_q = 0;
    end
  end

endmodule

// File: tb/ddl_tb.sv
`timescale 1ns/1ps
`include "ddl_defs.svh"

module ddl_tb;
  import ddl_cmd_pkg::*;
  import ddl_dfi_pkg::*;

  localparam int WAIT_LIMIT = 200;

  logic        clock = 1'b0;
  logic        reset;
  logic        ddr_cke_i;
  logic        ctl_run_o;
  logic        ctl_req_i;
  logic        ctl_rdy_o;
  ddl_opcode_e ctl_cmd_i;
  ddl_bank_t   ctl_ba_i;
  ddl_addr_t   ctl_adr_i;
  ddl_mask_t   mem_wrmask_i;
  ddl_data_t   mem_wrdata_i;
  logic        mem_wready_o;
  logic        mem_rvalid_o;
  ddl_data_t   mem_rddata_o;
  logic        dfi_ras_no;
  logic        dfi_cas_no;
  logic        dfi_we_no;
  ddl_bank_t   dfi_bank_o;
  ddl_addr_t   dfi_addr_o;
  logic        dfi_wstb_o;
  logic        dfi_wren_o;
  ddl_mask_t   dfi_mask_o;
  ddl_data_t   dfi_data_o;
  logic        dfi_rden_o;
  logic        dfi_rvld_i;
  ddl_data_t   dfi_data_i;
  integer      seed = 32'he89b7880;
  bit          timed_out = 0;
  int          error_count;
  int          test_count;

  always #50 clock = ~clock;

  ddr3_ddl dut0 (.*);

  ddl_checker chk0 (.*, .error_count_o(error_count), .test_count_o(test_count));

  // Move to the next falling edge with fresh random data on both data paths
  task automatic tick();
    @(negedge clock);
    mem_wrdata_i = ddl_data_t'($random(seed));
    mem_wrmask_i = ddl_mask_t'($random(seed));
    dfi_rvld_i   = 1'($random(seed));
    dfi_data_i   = ddl_data_t'($random(seed));
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!ctl_rdy_o && n < WAIT_LIMIT) begin
      tick();
      n++;
    end
    if (!ctl_rdy_o) begin
      $display("Timeout: ctl_rdy_o stayed low for %0d cycles", WAIT_LIMIT);
      timed_out = 1;
    end
  endtask

  // Hold a request for the given cycles once ready is high
  task automatic send(input ddl_opcode_e cmd, input bit ap, input int hold);
    if (!timed_out)
      wait_ready();
    if (!timed_out) begin
      ctl_req_i     = 1'b1;
      ctl_cmd_i     = cmd;
      ctl_ba_i      = ddl_bank_t'($random(seed));
      ctl_adr_i     = ddl_addr_t'($random(seed));
      ctl_adr_i[10] = ap;
      repeat (hold) tick();
      ctl_req_i = 1'b0;
    end
  endtask

  initial begin
    reset        = 1'b1;
    ddr_cke_i    = 1'b1;
    ctl_req_i    = 1'b0;
    ctl_cmd_i    = CMD_NOOP;
    ctl_ba_i     = '0;
    ctl_adr_i    = '0;
    mem_wrmask_i = '0;
    mem_wrdata_i = '0;
    dfi_rvld_i   = 1'b0;
    dfi_data_i   = '0;
    repeat (4) tick();
    reset = 1'b0;

    send(CMD_READ, 0, 2);
    send(CMD_MODE, 0, 1);
    send(CMD_MODE, 0, 1);
    send(CMD_ZQCL, 0, 1);
    send(CMD_ACTV, 0, 1);
    send(CMD_PREC, 0, 2);
    send(CMD_WRIT, 0, 1);
    send(CMD_WRIT, 0, 1);
    send(CMD_READ, 0, 1);
    send(CMD_READ, 0, 1);
    send(CMD_WRIT, 0, 1);
    send(CMD_ACTV, 0, 1);
    send(CMD_READ, 1, 1);
    send(CMD_NOOP, 0, 1);
    send(CMD_PREC, 0, 1);
    send(CMD_REFR, 0, 1);
    send(CMD_REFR, 0, 1);
    send(CMD_MODE, 0, 2);
    send(CMD_ACTV, 0, 1);
    send(CMD_ACTV, 0, 1);
    send(CMD_READ, 0, 1);
    send(CMD_ACTV, 0, 1);
    send(CMD_WRIT, 1, 1);
    send(CMD_PREC, 0, 1);
    send(CMD_NOOP, 0, 1);
    send(CMD_ACTV, 0, 1);
    send(CMD_WRIT, 0, 1);

    // Clock enable drop with a write burst still in flight
    tick();
    ddr_cke_i = 1'b0;
    repeat (3) tick();
    ddr_cke_i = 1'b1;

    send(CMD_ACTV, 0, 1);
    send(CMD_WRIT, 0, 1);
    send(CMD_READ, 1, 1);

    // Remaining exits from IDLE, MODE, ZQCL and PREC
    send(CMD_MODE, 0, 1);
    send(CMD_PREC, 0, 1);
    send(CMD_ACTV, 0, 1);
    send(CMD_READ, 1, 1);
    send(CMD_ZQCL, 0, 1);
    send(CMD_PREC, 0, 1);
    send(CMD_NOOP, 0, 1);
    send(CMD_MODE, 0, 1);
    send(CMD_REFR, 0, 1);
    send(CMD_ACTV, 0, 1);
    send(CMD_WRIT, 1, 1);
    send(CMD_ZQCL, 0, 1);
    send(CMD_REFR, 0, 1);
    send(CMD_ACTV, 0, 1);
    send(CMD_READ, 1, 1);
    send(CMD_REFR, 0, 1);
    if (!timed_out)
      wait_ready();
    repeat (12) tick();

    $display("Tests run: %0d, errors: %0d, assertion failures: %0d",
             test_count, error_count, dut0.props0.assert_errors);
    if (!timed_out && error_count == 0 && dut0.props0.assert_errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: sim.f
+incdir+include
hdl/ddl_cmd_pkg.sv
hdl/ddl_dfi_pkg.sv
hdl/ddl_cmd_decode.sv
hdl/ddl_cmd_execute.sv
hdl/ddl_burst_timer.sv
hdl/ddr3_ddl.sv
tb/ddl_properties.sv
tb/ddl_checker.sv
tb/ddl_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module ddl_tb -o ddl_sim

output=$(./obj_dir/ddl_sim)
echo "$output"

if grep -q "Test completed successfully" <<< "$output"; then
  exit 0
else
  exit 1
fi
